/* source/systolic_dims_pkg.sv */
// fixed 4x4 tile only, signed 8-bit operands, 24-bit accumulators that wrap on overflow
`default_nettype none

package systolic_dims_pkg;

    localparam int unsigned ARRAY_N   = 4;
    localparam int unsigned DATA_W    = 8;
    localparam int unsigned ACC_W     = 24;
    localparam int unsigned ROW_IDX_W = 2;

    typedef logic signed [DATA_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // element 0 sits in the low bits
    typedef elem_t [ARRAY_N-1:0] vec_t;
    typedef acc_t  [ARRAY_N-1:0] acc_row_t;

    // indexed by B row, then by column
    typedef vec_t [ARRAY_N-1:0] weight_mat_t;

endpackage

`default_nettype wire

/* source/systolic_ctrl_pkg.sv */
// pass sequencing for one tile; every pass moves exactly ARRAY_N rows on each stream
`default_nettype none

package systolic_ctrl_pkg;

    // rows per pass for B loading, A streaming and buffer writes
    localparam int unsigned PASS_ROWS = systolic_dims_pkg::ARRAY_N;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_LOAD_W = 3'd1,
        ST_STREAM = 3'd2,
        ST_DRAIN  = 3'd3,
        ST_DONE   = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/weight_loader.sv */
// B rows arrive in order 0..3; a partial load leaves the row counter mid-matrix
`timescale 1ns/10ps
`default_nettype none

module weight_loader (
    input  wire                                  s_clk,
    input  wire                                  s_rst,
    input  wire                                  i_b_valid,
    input  wire systolic_dims_pkg::vec_t         i_b_data,
    input  wire                                  i_load_en,
    output logic                                 o_b_ready,
    output systolic_dims_pkg::weight_mat_t       o_weights,
    output logic                                 o_load_last
);
    import systolic_dims_pkg::*;

    logic [ROW_IDX_W-1:0] row_cnt;
    logic                 accept;

    assign o_b_ready   = i_load_en;
    assign accept      = i_b_valid & i_load_en;
    assign o_load_last = accept && (row_cnt == ROW_IDX_W'(ARRAY_N - 1));

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            row_cnt <= '0;
        end else if (accept) begin
            // wraps back to row 0 after the last beat
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // weights stay put until the next load
    always_ff @(posedge s_clk) begin
        if (accept) begin
            o_weights[row_cnt] <= i_b_data;
        end
    end

endmodule

`default_nettype wire

/* source/systolic_pe.sv */
// one MAC cell; product is sign-extended to ACC_W and the column sum wraps
`timescale 1ns/10ps
`default_nettype none

module systolic_pe (
    input  wire                            s_clk,
    input  wire                            s_rst,
    input  wire systolic_dims_pkg::elem_t  i_a,
    input  wire                            i_a_valid,
    input  wire systolic_dims_pkg::elem_t  i_weight,
    input  wire systolic_dims_pkg::acc_t   i_psum,
    output systolic_dims_pkg::elem_t       o_a,
    output logic                           o_a_valid,
    output systolic_dims_pkg::acc_t        o_psum
);
    import systolic_dims_pkg::*;

    acc_t prod;

    // idle cells pass the column sum through untouched
    assign prod = i_a_valid ? acc_t'(i_a * i_weight) : '0;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_a_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        o_a    <= i_a;
        o_psum <= i_psum + prod;
    end

endmodule

`default_nettype wire

/* source/pe_grid.sv */
// fixed 8-cycle latency per row, never stalls; up to four A rows in flight at once
`timescale 1ns/10ps
`default_nettype none

module pe_grid (
    input  wire                                  s_clk,
    input  wire                                  s_rst,
    input  wire systolic_dims_pkg::vec_t         i_row,
    input  wire                                  i_row_valid,
    input  wire systolic_dims_pkg::weight_mat_t  i_weights,
    output systolic_dims_pkg::acc_row_t          o_c_row,
    output logic                                 o_c_valid
);
    import systolic_dims_pkg::*;

    // stage k holds the row accepted k+1 cycles ago
    vec_t               skew_q [ARRAY_N];
    logic [ARRAY_N-1:0] skew_v;
    acc_row_t           dsk_q [ARRAY_N-1];

    wire elem_t    a_w    [ARRAY_N][ARRAY_N+1];
    wire           av_w   [ARRAY_N][ARRAY_N+1];
    wire acc_t     psum_w [ARRAY_N+1][ARRAY_N];
    wire acc_row_t bottom;
    wire acc_row_t aligned;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            skew_v    <= '0;
            o_c_valid <= 1'b0;
        end else begin
            skew_v    <= {skew_v[ARRAY_N-2:0], i_row_valid};
            // last cell's operand valid lines up with the deskewed row
            o_c_valid <= av_w[ARRAY_N-1][ARRAY_N];
        end
    end

    always_ff @(posedge s_clk) begin
        skew_q[0] <= i_row;
        dsk_q[0]  <= bottom;
        for (int k = 1; k < ARRAY_N; k++) begin
            skew_q[k] <= skew_q[k-1];
        end
        for (int k = 1; k < ARRAY_N - 1; k++) begin
            dsk_q[k] <= dsk_q[k-1];
        end
        o_c_row <= aligned;
    end

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
        // element r enters grid row r after r+1 register stages
        assign a_w[r][0]  = skew_q[r][r];
        assign av_w[r][0] = skew_v[r];
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
            systolic_pe u_pe (
                .s_clk     (s_clk),
                .s_rst     (s_rst),
                .i_a       (a_w[r][c]),
                .i_a_valid (av_w[r][c]),
                .i_weight  (i_weights[r][c]),
                .i_psum    (psum_w[r][c]),
                .o_a       (a_w[r][c+1]),
                .o_a_valid (av_w[r][c+1]),
                .o_psum    (psum_w[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < ARRAY_N; c++) begin : g_edge
        assign psum_w[0][c] = '0;
        assign bottom[c]    = psum_w[ARRAY_N][c];
        if (c == ARRAY_N - 1) begin : g_last
            assign aligned[c] = bottom[c];
        end else begin : g_dly
            // column c leaves the grid ARRAY_N-1-c cycles early
            assign aligned[c] = dsk_q[ARRAY_N-2-c][c];
        end
    end

endmodule

`default_nettype wire

/* source/psum_buffer.sv */
// rows land in arrival order; contents are undefined until the first pass has written them
`timescale 1ns/10ps
`default_nettype none

module psum_buffer (
    input  wire                                   s_clk,
    input  wire                                   s_rst,
    input  wire systolic_dims_pkg::acc_row_t      i_c_row,
    input  wire                                   i_c_valid,
    input  wire                                   i_accum,
    input  wire [systolic_dims_pkg::ROW_IDX_W-1:0] i_rd_row,
    output systolic_dims_pkg::acc_row_t           o_rd_data,
    output logic                                  o_row_written
);
    import systolic_dims_pkg::*;

    acc_row_t             rows_q [ARRAY_N];
    acc_row_t             wr_row;
    logic [ROW_IDX_W-1:0] wr_idx;

    // overwrite or add, each lane wraps at ACC_W
    always_comb begin
        for (int e = 0; e < ARRAY_N; e++) begin
            wr_row[e] = i_accum ? rows_q[wr_idx][e] + i_c_row[e] : i_c_row[e];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_idx        <= '0;
            o_row_written <= 1'b0;
        end else begin
            o_row_written <= i_c_valid;
            if (i_c_valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_c_valid) begin
            rows_q[wr_idx] <= wr_row;
        end
    end

    assign o_rd_data = rows_q[i_rd_row];

endmodule

`default_nettype wire

/* source/systolic_ctrl.sv */
// one pass is B load, A stream, drain; init clears accumulation for the pass that follows
`timescale 1ns/10ps
`default_nettype none

module systolic_ctrl (
    input  wire  s_clk,
    input  wire  s_rst,
    input  wire  i_init,
    input  wire  i_a_valid,
    input  wire  i_load_last,
    input  wire  i_row_written,
    output logic o_load_en,
    output logic o_a_ready,
    output logic o_a_fire,
    output logic o_accum,
    output logic o_done
);
    import systolic_dims_pkg::*;
    import systolic_ctrl_pkg::*;

    ctrl_state_t          state;
    ctrl_state_t          state_nx;
    logic [ROW_IDX_W-1:0] a_cnt;
    logic [ROW_IDX_W-1:0] wr_cnt;
    logic                 a_last;
    logic                 wr_last;

    assign o_load_en = (state == ST_LOAD_W);
    assign o_a_ready = (state == ST_STREAM);
    assign o_done    = (state == ST_DONE);
    // accepted A row, doubles as the grid's row valid
    assign o_a_fire  = i_a_valid & o_a_ready;
    assign a_last    = o_a_fire && (a_cnt == ROW_IDX_W'(PASS_ROWS - 1));
    assign wr_last   = i_row_written && (wr_cnt == ROW_IDX_W'(PASS_ROWS - 1));

    always_comb begin
        state_nx = state;
        unique case (state)
            ST_IDLE:   state_nx = ST_LOAD_W;
            ST_LOAD_W: if (i_load_last) state_nx = ST_STREAM;
            ST_STREAM: if (a_last) state_nx = ST_DRAIN;
            ST_DRAIN:  if (wr_last) state_nx = ST_DONE;
            ST_DONE:   state_nx = ST_IDLE;
            default:   state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state   <= ST_IDLE;
            a_cnt   <= '0;
            wr_cnt  <= '0;
            o_accum <= 1'b0;
        end else begin
            state <= state_nx;
            if (o_a_fire) begin
                a_cnt <= a_cnt + 1'b1;
            end
            // early rows can land while A is still streaming
            if (i_row_written) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (i_init) begin
                o_accum <= 1'b0;
            end else if (state == ST_DONE) begin
                o_accum <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/systolic_top.sv */
// B must be reloaded every pass; read results back only between passes
`timescale 1ns/10ps
`default_nettype none

module systolic_top (
    input  wire                                   s_clk,
    input  wire                                   s_rst,
    input  wire                                   i_init,
    input  wire                                   i_b_valid,
    input  wire systolic_dims_pkg::vec_t          i_b_data,
    input  wire                                   i_a_valid,
    input  wire systolic_dims_pkg::vec_t          i_a_data,
    input  wire [systolic_dims_pkg::ROW_IDX_W-1:0] i_rd_row,
    output logic                                  o_b_ready,
    output logic                                  o_a_ready,
    output systolic_dims_pkg::acc_row_t           o_rd_data,
    output logic                                  o_done
);
    import systolic_dims_pkg::*;

    weight_mat_t weights;
    acc_row_t    c_row;
    logic        load_en;
    logic        load_last;
    logic        a_fire;
    logic        accum;
    logic        c_valid;
    logic        row_written;

    weight_loader u_loader (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_b_valid   (i_b_valid),
        .i_b_data    (i_b_data),
        .i_load_en   (load_en),
        .o_b_ready   (o_b_ready),
        .o_weights   (weights),
        .o_load_last (load_last)
    );

    systolic_ctrl u_ctrl (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_init        (i_init),
        .i_a_valid     (i_a_valid),
        .i_load_last   (load_last),
        .i_row_written (row_written),
        .o_load_en     (load_en),
        .o_a_ready     (o_a_ready),
        .o_a_fire      (a_fire),
        .o_accum       (accum),
        .o_done        (o_done)
    );

    pe_grid u_grid (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_row       (i_a_data),
        .i_row_valid (a_fire),
        .i_weights   (weights),
        .o_c_row     (c_row),
        .o_c_valid   (c_valid)
    );

    psum_buffer u_psum (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_c_row       (c_row),
        .i_c_valid     (c_valid),
        .i_accum       (accum),
        .i_rd_row      (i_rd_row),
        .o_rd_data     (o_rd_data),
        .o_row_written (row_written)
    );

endmodule

`default_nettype wire

/* tb/systolic_asserts.sv */
// stream and done checks sampled on the rising edge; hold checks are off during reset
`timescale 1ns/10ps
`default_nettype none

module systolic_asserts (
    input wire                          s_clk,
    input wire                          s_rst,
    input wire                          i_b_valid,
    input wire systolic_dims_pkg::vec_t i_b_data,
    input wire                          i_a_valid,
    input wire systolic_dims_pkg::vec_t i_a_data,
    input wire                          o_b_ready,
    input wire                          o_a_ready,
    input wire                          o_done
);

    // loading and streaming never overlap
    ready_exclusive: assert property (@(posedge s_clk) disable iff (s_rst)
        !(o_a_ready && o_b_ready))
        else $error("o_a_ready and o_b_ready high in the same cycle");

    b_hold: assert property (@(posedge s_clk) disable iff (s_rst)
        (i_b_valid && !o_b_ready) |=> (i_b_valid && $stable(i_b_data)))
        else $error("B beat dropped or changed before o_b_ready");

    a_hold: assert property (@(posedge s_clk) disable iff (s_rst)
        (i_a_valid && !o_a_ready) |=> (i_a_valid && $stable(i_a_data)))
        else $error("A beat dropped or changed before o_a_ready");

    done_single: assert property (@(posedge s_clk) disable iff (s_rst)
        o_done |=> !o_done)
        else $error("o_done high for more than one cycle");

    quiet_in_reset: assert property (@(posedge s_clk)
        s_rst |-> (!o_a_ready && !o_b_ready && !o_done))
        else $error("ready or done high during reset");

endmodule

`default_nettype wire

/* tb/systolic_tb.sv */
// drives one 4x4 tile per pass and reads rows back after o_done; B is reloaded every pass
`timescale 1ns/10ps
`default_nettype none

module systolic_tb;
    import systolic_dims_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;
    localparam int DONE_LIMIT  = 100;

    logic                 s_clk;
    logic                 s_rst;
    logic                 i_init;
    logic                 i_b_valid;
    vec_t                 i_b_data;
    logic                 i_a_valid;
    vec_t                 i_a_data;
    logic [ROW_IDX_W-1:0] i_rd_row;
    logic                 o_b_ready;
    logic                 o_a_ready;
    acc_row_t             o_rd_data;
    logic                 o_done;

    int    seed = 32'h6b10;
    int    done_cnt = 0;
    int    err_cnt;
    int    total_err;
    int    fail_tests;
    string cur_test;

    elem_t a_mat   [ARRAY_N][ARRAY_N];
    elem_t b_mat   [ARRAY_N][ARRAY_N];
    acc_t  exp_mat [ARRAY_N][ARRAY_N];

    // idle cycles before each beat
    int    b_gap [ARRAY_N];
    int    a_gap [ARRAY_N];

    systolic_top dut0 (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_init    (i_init),
        .i_b_valid (i_b_valid),
        .i_b_data  (i_b_data),
        .i_a_valid (i_a_valid),
        .i_a_data  (i_a_data),
        .i_rd_row  (i_rd_row),
        .o_b_ready (o_b_ready),
        .o_a_ready (o_a_ready),
        .o_rd_data (o_rd_data),
        .o_done    (o_done)
    );

    bind systolic_top systolic_asserts u_asserts (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_b_valid (i_b_valid),
        .i_b_data  (i_b_data),
        .i_a_valid (i_a_valid),
        .i_a_data  (i_a_data),
        .o_b_ready (o_b_ready),
        .o_a_ready (o_a_ready),
        .o_done    (o_done)
    );

    initial begin
        s_clk = 1'b0;
        forever #(CLK_PERIOD / 2) s_clk = ~s_clk;
    end

    // o_done is settled at the falling edge
    always @(negedge s_clk) begin
        if (!s_rst && o_done) begin
            done_cnt++;
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before all tests finished");
        $display("Testbench failed");
        $finish;
    end

    task automatic fill_random(input bit identity_b);
        for (int r = 0; r < ARRAY_N; r++) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                a_mat[r][c] = elem_t'($random(seed));
                if (identity_b) begin
                    b_mat[r][c] = (r == c) ? 8'sd1 : 8'sd0;
                end else begin
                    b_mat[r][c] = elem_t'($random(seed));
                end
            end
        end
    endtask

    // C = A x B per element, optionally added to what is stored; wraps at ACC_W
    task automatic model_pass(input bit accumulate);
        acc_t sum;
        for (int i = 0; i < ARRAY_N; i++) begin
            for (int j = 0; j < ARRAY_N; j++) begin
                sum = '0;
                for (int k = 0; k < ARRAY_N; k++) begin
                    sum = sum + acc_t'(a_mat[i][k]) * acc_t'(b_mat[k][j]);
                end
                exp_mat[i][j] = accumulate ? exp_mat[i][j] + sum : sum;
            end
        end
    endtask

    // identity B gives A back, sign-extended
    task automatic model_identity();
        for (int i = 0; i < ARRAY_N; i++) begin
            for (int j = 0; j < ARRAY_N; j++) begin
                exp_mat[i][j] = acc_t'(a_mat[i][j]);
            end
        end
    endtask

    function automatic vec_t pack_row(input bit from_b, input int r);
        vec_t v;
        for (int c = 0; c < ARRAY_N; c++) begin
            v[c] = from_b ? b_mat[r][c] : a_mat[r][c];
        end
        return v;
    endfunction

    task automatic draw_gaps(input bit gaps);
        for (int r = 0; r < ARRAY_N; r++) begin
            b_gap[r] = gaps ? ($random(seed) & 3) : 0;
            a_gap[r] = gaps ? ($random(seed) & 3) : 0;
        end
    endtask

    // valid and data held until the edge that sees ready
    task automatic send_b();
        for (int r = 0; r < ARRAY_N; r++) begin
            repeat (b_gap[r]) @(negedge s_clk);
            i_b_valid = 1'b1;
            i_b_data  = pack_row(1'b1, r);
            while (!o_b_ready) @(negedge s_clk);
            @(negedge s_clk);
            i_b_valid = 1'b0;
        end
    endtask

    task automatic send_a();
        for (int r = 0; r < ARRAY_N; r++) begin
            repeat (a_gap[r]) @(negedge s_clk);
            i_a_valid = 1'b1;
            i_a_data  = pack_row(1'b0, r);
            while (!o_a_ready) @(negedge s_clk);
            @(negedge s_clk);
            i_a_valid = 1'b0;
        end
    endtask

    task automatic run_pass(input bit gaps);
        int start;
        int waited;
        start  = done_cnt;
        waited = 0;
        draw_gaps(gaps);
        fork
            send_b();
            send_a();
        join
        while (done_cnt == start && waited < DONE_LIMIT) begin
            @(negedge s_clk);
            waited++;
        end
        @(negedge s_clk);
        if (done_cnt == start) begin
            $display("ERROR: %s never saw o_done within %0d cycles", cur_test, DONE_LIMIT);
            err_cnt++;
        end else begin
            assert (done_cnt - start == 1) else begin
                $display("[FAIL] %s done pulses: expected 1, actual %0d", cur_test,
                         done_cnt - start);
                err_cnt++;
            end
        end
    endtask

    task automatic check_rows();
        acc_row_t exp_row;
        for (int r = 0; r < ARRAY_N; r++) begin
            i_rd_row = ROW_IDX_W'(r);
            @(negedge s_clk);
            for (int c = 0; c < ARRAY_N; c++) begin
                exp_row[c] = exp_mat[r][c];
            end
            assert (o_rd_data === exp_row) else begin
                $display("[FAIL] %s row %0d: expected %h, actual %h", cur_test, r,
                         exp_row, o_rd_data);
                err_cnt++;
            end
        end
    endtask

    task automatic pulse_init();
        i_init = 1'b1;
        @(negedge s_clk);
        i_init = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_cnt  = 0;
    endtask

    task automatic end_test();
        if (err_cnt == 0) begin
            $display("test %s finished: ok", cur_test);
        end else begin
            $display("test %s finished: %0d errors", cur_test, err_cnt);
            fail_tests++;
            total_err += err_cnt;
        end
    endtask

    initial begin
        s_rst      = 1'b1;
        i_init     = 1'b0;
        i_b_valid  = 1'b0;
        i_b_data   = '0;
        i_a_valid  = 1'b0;
        i_a_data   = '0;
        i_rd_row   = '0;
        total_err  = 0;
        fail_tests = 0;
        repeat (5) @(negedge s_clk);
        s_rst = 1'b0;

        // controller still idle here, so the first B beat waits on ready
        begin_test("identity");
        fill_random(1'b1);
        model_identity();
        fork
            pulse_init();
            run_pass(1'b0);
        join
        check_rows();
        end_test();

        begin_test("random_product");
        pulse_init();
        fill_random(1'b0);
        model_pass(1'b0);
        run_pass(1'b0);
        check_rows();
        end_test();

        // no init, so this pass adds onto the last one
        begin_test("accumulate");
        fill_random(1'b0);
        model_pass(1'b1);
        run_pass(1'b0);
        check_rows();
        end_test();

        begin_test("init_overwrite");
        pulse_init();
        fill_random(1'b0);
        model_pass(1'b0);
        run_pass(1'b0);
        check_rows();
        end_test();

        begin_test("backpressure_gaps");
        pulse_init();
        fill_random(1'b0);
        model_pass(1'b0);
        run_pass(1'b1);
        check_rows();
        fill_random(1'b0);
        model_pass(1'b1);
        run_pass(1'b1);
        check_rows();
        end_test();

        $display("tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS, fail_tests, total_err);
        if (fail_tests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/systolic_dims_pkg.sv
source/systolic_ctrl_pkg.sv
source/weight_loader.sv
source/systolic_pe.sv
source/pe_grid.sv
source/psum_buffer.sv
source/systolic_ctrl.sv
source/systolic_top.sv
tb/systolic_asserts.sv
tb/systolic_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= systolic_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
